//--- Bender.yml
package:
  name: serial_line

sources:
  # Packages first, then the RTL in dependency order
  - files:
      - hdl/lineFmtPkg.sv
      - hdl/hostCmdPkg.sv
      - hdl/baudTickGen.sv
      - hdl/serialRx.sv
      - hdl/serialTx.sv
      - hdl/lineRegs.sv
      - hdl/serialLineTop.sv
  # Testbench top and its helper header
  - target: test
    include_dirs:
      - test
    files:
      - test/serialLineTb.sv

//--- hdl/baudTickGen.sv
`timescale 1ns/1ps

module baudTickGen #(
   parameter int DIV_W = 12
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [DIV_W-1:0] divisor,
   output logic             baudTick
);

   // Down-counter and the divisor it was loaded from
   logic [DIV_W-1:0] count;
   logic [DIV_W-1:0] lastDiv;

   // One tick every divisor+1 clocks, 16 ticks per bit
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         count    <= '1;
         lastDiv  <= '1;
         baudTick <= 1'b0;
      end
      else if (divisor != lastDiv)
      begin
         // New rate, restart the count from the top
         count    <= divisor;
         lastDiv  <= divisor;
         baudTick <= 1'b0;
      end
      else if (count == '0)
      begin
         count    <= divisor;
         baudTick <= 1'b1;
      end
      else
      begin
         count    <= count - 1'b1;
         baudTick <= 1'b0;
      end
   end

endmodule

//--- hdl/hostCmdPkg.sv
package hostCmdPkg;

   ////////////////////
   // Host opcodes
   ////////////////////

   // SET_LINE data: [1:0] length, [3:2] parity, [4] stop bits
   // SET_DIV data: low bits are the baud divisor
   typedef enum logic [1:0] {
      OP_NOP,
      OP_SET_LINE,
      OP_SET_DIV,
      OP_FLUSH
   } cfgOp_t;

   ////////////////////
   // Receive status
   ////////////////////

   // Error flags delivered alongside each character
   typedef struct packed {
      logic parErr;
      logic frmErr;
      logic ovrErr;
   } rxStat_t;

endpackage

//--- hdl/lineFmtPkg.sv
package lineFmtPkg;

   ////////////////////
   // Character width
   ////////////////////

   // Widest character the line carries
   localparam int CHAR_W = 8;

   ////////////////////
   // Line format fields
   ////////////////////

   // Data bits per character
   typedef enum logic [1:0] {
      LEN5,
      LEN6,
      LEN7,
      LEN8
   } charLen_t;

   // Parity sense, none skips the parity slot
   typedef enum logic [1:0] {
      PAR_NONE,
      PAR_EVEN,
      PAR_ODD
   } parity_t;

   // Stop bit count
   typedef enum logic {
      STOP1,
      STOP2
   } stopBits_t;

endpackage

//--- hdl/lineRegs.sv
`timescale 1ns/1ps

module lineRegs #(
   parameter int DIV_W     = 12,
   parameter int RXQ_DEPTH = 4
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          cfgWrite,
   input  hostCmdPkg::cfgOp_t            cfgOp,
   input  logic [15:0]                   cfgData,
   input  logic                          rxCredit,
   input  logic                          txValid,
   input  logic [lineFmtPkg::CHAR_W-1:0] txData,
   input  logic                          charDone,
   input  logic                          parErr,
   input  logic                          frmErr,
   input  logic                          txBusy,
   input  logic [lineFmtPkg::CHAR_W-1:0] rxChar,
   output lineFmtPkg::charLen_t          charLen,
   output lineFmtPkg::parity_t           parity,
   output lineFmtPkg::stopBits_t         stopBits,
   output logic [DIV_W-1:0]              divisor,
   output logic                          flush,
   output logic                          rxValid,
   output logic [lineFmtPkg::CHAR_W-1:0] rxData,
   output hostCmdPkg::rxStat_t           rxStat,
   output logic                          txCredit,
   output logic                          txStart,
   output logic [lineFmtPkg::CHAR_W-1:0] txChar
);

   import lineFmtPkg::*;
   import hostCmdPkg::*;

   localparam int PTR_W = (RXQ_DEPTH > 1) ? $clog2(RXQ_DEPTH) : 1;
   localparam int CNT_W = $clog2(RXQ_DEPTH + 1);

   // Receive queue storage
   logic [CHAR_W-1:0] qChar [RXQ_DEPTH];
   rxStat_t           qStat [RXQ_DEPTH];
   logic [PTR_W-1:0]  wrPtr;
   logic [PTR_W-1:0]  rdPtr;
   logic [PTR_W-1:0]  newest;
   logic [CNT_W-1:0]  qCount;
   logic              qFull;
   logic              enqReq;
   logic              enqAccept;
   logic              qOvr;
   logic              deq;
   logic [7:0]        rxCredits;
   // Transmit holding register
   logic              holdFull;
   logic [CHAR_W-1:0] holdData;

   function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(RXQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   ////////////////////
   // Configuration
   ////////////////////

   // Flush acts at the same edge as the write
   assign flush = cfgWrite && (cfgOp == OP_FLUSH);

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         charLen  <= LEN8;
         parity   <= PAR_NONE;
         stopBits <= STOP1;
         divisor  <= '1;
      end
      else if (cfgWrite && (cfgOp == OP_SET_LINE))
      begin
         charLen  <= charLen_t'(cfgData[1:0]);
         parity   <= parity_t'(cfgData[3:2]);
         stopBits <= stopBits_t'(cfgData[4]);
      end
      else if (cfgWrite && (cfgOp == OP_SET_DIV))
         divisor <= cfgData[DIV_W-1:0];
   end

   ////////////////////
   // Receive queue
   ////////////////////

   // Deliver only against a held credit
   assign rxValid   = (qCount != '0) && (rxCredits != '0) && !flush;
   assign deq       = rxValid;
   assign rxData    = qChar[rdPtr];
   assign rxStat    = qStat[rdPtr];
   assign qFull     = (qCount == CNT_W'(RXQ_DEPTH));
   // A dequeue in the same cycle frees the slot
   assign enqAccept = enqReq && (!qFull || deq);
   assign qOvr      = enqReq && qFull && !deq;
   assign newest    = (wrPtr == '0) ? PTR_W'(RXQ_DEPTH - 1) : wrPtr - 1'b1;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr  <= '0;
         rdPtr  <= '0;
         qCount <= '0;
         enqReq <= 1'b0;
      end
      else if (flush)
      begin
         wrPtr  <= '0;
         rdPtr  <= '0;
         qCount <= '0;
         enqReq <= 1'b0;
      end
      else
      begin
         // Enqueue one cycle after charDone
         enqReq <= charDone;
         if (deq)
            rdPtr <= nextPtr(rdPtr);
         if (enqAccept)
            wrPtr <= nextPtr(wrPtr);
         if (enqAccept && !deq)
            qCount <= qCount + 1'b1;
         else if (deq && !enqAccept)
            qCount <= qCount - 1'b1;
      end
   end

   // Full queue drops the char and marks the newest entry
   always_ff @(posedge clk)
   begin
      if (enqAccept)
      begin
         qChar[wrPtr] <= rxChar;
         qStat[wrPtr] <= '{parErr: parErr, frmErr: frmErr, ovrErr: 1'b0};
      end
      else if (qOvr)
         qStat[newest].ovrErr <= 1'b1;
   end

   // Receive credits, saturating
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rxCredits <= '0;
      else if (rxCredit && !(&rxCredits) && !deq)
         rxCredits <= rxCredits + 1'b1;
      else if (deq && !(rxCredit && !(&rxCredits)))
         rxCredits <= rxCredits - 1'b1;
   end

   ////////////////////
   // Transmit holding
   ////////////////////

   assign txStart = holdFull && !txBusy;
   assign txChar  = holdData;

   // Credit goes back the cycle after launch
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         holdFull <= 1'b0;
         txCredit <= 1'b0;
      end
      else if (flush)
      begin
         holdFull <= 1'b0;
         txCredit <= 1'b0;
      end
      else
      begin
         txCredit <= txStart;
         if (txStart)
            holdFull <= 1'b0;
         else if (txValid)
            holdFull <= 1'b1;
      end
   end

   // Writes while full are dropped
   always_ff @(posedge clk)
   begin
      if (txValid && !holdFull)
         holdData <= txData;
   end

endmodule

//--- hdl/serialLineTop.sv
`timescale 1ns/1ps

module serialLineTop #(
   parameter int DIV_W     = 12,
   parameter int RXQ_DEPTH = 4
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          cfgWrite,
   input  hostCmdPkg::cfgOp_t            cfgOp,
   input  logic [15:0]                   cfgData,
   input  logic                          rxCredit,
   output logic                          rxValid,
   output logic [lineFmtPkg::CHAR_W-1:0] rxData,
   output hostCmdPkg::rxStat_t           rxStat,
   input  logic                          txValid,
   input  logic [lineFmtPkg::CHAR_W-1:0] txData,
   output logic                          txCredit,
   input  logic                          rxd,
   output logic                          txd
);

   import lineFmtPkg::*;

   // Line format and control from the register block
   charLen_t          charLen;
   parity_t           parity;
   stopBits_t         stopBits;
   logic [DIV_W-1:0]  divisor;
   logic              flush;
   logic              baudTick;
   // Receiver to register block
   logic              charDone;
   logic [CHAR_W-1:0] rxChar;
   logic              parErr;
   logic              frmErr;
   // Register block to transmitter
   logic              txStart;
   logic [CHAR_W-1:0] txChar;
   logic              txBusy;

   lineRegs #(
      .DIV_W     (DIV_W),
      .RXQ_DEPTH (RXQ_DEPTH)
   ) regs (
      .clk      (clk),
      .rst      (rst),
      .cfgWrite (cfgWrite),
      .cfgOp    (cfgOp),
      .cfgData  (cfgData),
      .rxCredit (rxCredit),
      .txValid  (txValid),
      .txData   (txData),
      .charDone (charDone),
      .parErr   (parErr),
      .frmErr   (frmErr),
      .txBusy   (txBusy),
      .rxChar   (rxChar),
      .charLen  (charLen),
      .parity   (parity),
      .stopBits (stopBits),
      .divisor  (divisor),
      .flush    (flush),
      .rxValid  (rxValid),
      .rxData   (rxData),
      .rxStat   (rxStat),
      .txCredit (txCredit),
      .txStart  (txStart),
      .txChar   (txChar)
   );

   baudTickGen #(
      .DIV_W (DIV_W)
   ) brg (
      .clk      (clk),
      .rst      (rst),
      .divisor  (divisor),
      .baudTick (baudTick)
   );

   serialRx rx (
      .clk      (clk),
      .rst      (rst),
      .flush    (flush),
      .baudTick (baudTick),
      .rxd      (rxd),
      .charLen  (charLen),
      .parity   (parity),
      .stopBits (stopBits),
      .charDone (charDone),
      .rxChar   (rxChar),
      .parErr   (parErr),
      .frmErr   (frmErr)
   );

   serialTx tx (
      .clk      (clk),
      .rst      (rst),
      .flush    (flush),
      .baudTick (baudTick),
      .txStart  (txStart),
      .txChar   (txChar),
      .charLen  (charLen),
      .parity   (parity),
      .stopBits (stopBits),
      .txd      (txd),
      .txBusy   (txBusy)
   );

endmodule

//--- hdl/serialRx.sv
`timescale 1ns/1ps

module serialRx (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          flush,
   input  logic                          baudTick,
   input  logic                          rxd,
   input  lineFmtPkg::charLen_t          charLen,
   input  lineFmtPkg::parity_t           parity,
   input  lineFmtPkg::stopBits_t         stopBits,
   output logic                          charDone,
   output logic [lineFmtPkg::CHAR_W-1:0] rxChar,
   output logic                          parErr,
   output logic                          frmErr
);

   import lineFmtPkg::*;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_PARITY,
      RX_STOP1,
      RX_STOP2,
      RX_WAIT,
      RX_DONE
   } rxState_t;

   rxState_t   state;
   logic       rxdMeta;
   logic       rxdSync;
   logic [3:0] tickCnt;
   logic [2:0] bitCnt;
   logic [2:0] lastBit;
   logic       parAcc;

   ////////////////////
   // Input synchronizer
   ////////////////////

   // Two flops, idle line is high
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rxdMeta <= 1'b1;
         rxdSync <= 1'b1;
      end
      else
      begin
         rxdMeta <= rxd;
         rxdSync <= rxdMeta;
      end
   end

   // Index of the last data bit, 4 to 7
   assign lastBit = {1'b0, charLen} + 3'd4;

   ////////////////////
   // Receive FSM
   ////////////////////

   // Sample mid-bit: 8 ticks into start, then every 16
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state   <= RX_IDLE;
         tickCnt <= '0;
         bitCnt  <= '0;
         parAcc  <= 1'b0;
         rxChar  <= '0;
         parErr  <= 1'b0;
         frmErr  <= 1'b0;
      end
      else if (flush)
      begin
         state   <= RX_IDLE;
         tickCnt <= '0;
         bitCnt  <= '0;
         parAcc  <= 1'b0;
         rxChar  <= '0;
         parErr  <= 1'b0;
         frmErr  <= 1'b0;
      end
      else
      begin
         case (state)
            // Look for the falling start edge
            RX_IDLE:
               if (baudTick && !rxdSync)
               begin
                  tickCnt <= 4'd7;
                  state   <= RX_START;
               end
            // Start bit must hold low for half a bit
            RX_START:
               if (baudTick)
               begin
                  if (rxdSync)
                     state <= RX_IDLE;
                  else if (tickCnt == '0)
                  begin
                     tickCnt <= 4'd15;
                     bitCnt  <= '0;
                     parAcc  <= 1'b0;
                     rxChar  <= '0;
                     parErr  <= 1'b0;
                     frmErr  <= 1'b0;
                     state   <= RX_DATA;
                  end
                  else
                     tickCnt <= tickCnt - 1'b1;
               end
            // LSB first, each bit lands in place so short chars stay right-aligned
            RX_DATA:
               if (baudTick)
               begin
                  if (tickCnt == '0)
                  begin
                     rxChar[bitCnt] <= rxdSync;
                     parAcc         <= parAcc ^ rxdSync;
                     tickCnt        <= 4'd15;
                     if (bitCnt == lastBit)
                        state <= (parity == PAR_NONE) ? RX_STOP1 : RX_PARITY;
                     else
                        bitCnt <= bitCnt + 1'b1;
                  end
                  else
                     tickCnt <= tickCnt - 1'b1;
               end
            // Odd sense flips the expected total
            RX_PARITY:
               if (baudTick)
               begin
                  if (tickCnt == '0)
                  begin
                     parErr  <= rxdSync ^ parAcc ^ (parity == PAR_ODD);
                     tickCnt <= 4'd15;
                     state   <= RX_STOP1;
                  end
                  else
                     tickCnt <= tickCnt - 1'b1;
               end
            RX_STOP1:
               if (baudTick)
               begin
                  if (tickCnt == '0)
                  begin
                     if (!rxdSync)
                        frmErr <= 1'b1;
                     if (stopBits == STOP2)
                     begin
                        tickCnt <= 4'd15;
                        state   <= RX_STOP2;
                     end
                     else
                     begin
                        tickCnt <= 4'd7;
                        state   <= RX_WAIT;
                     end
                  end
                  else
                     tickCnt <= tickCnt - 1'b1;
               end
            RX_STOP2:
               if (baudTick)
               begin
                  if (tickCnt == '0)
                  begin
                     if (!rxdSync)
                        frmErr <= 1'b1;
                     tickCnt <= 4'd7;
                     state   <= RX_WAIT;
                  end
                  else
                     tickCnt <= tickCnt - 1'b1;
               end
            // Run out the second half of the last stop bit
            RX_WAIT:
               if (baudTick)
               begin
                  if (tickCnt == '0)
                     state <= RX_DONE;
                  else
                     tickCnt <= tickCnt - 1'b1;
               end
            RX_DONE:
               state <= RX_IDLE;
            default:
               state <= RX_IDLE;
         endcase
      end
   end

   // Single clock pulse per character
   assign charDone = (state == RX_DONE);

endmodule

//--- hdl/serialTx.sv
`timescale 1ns/1ps

module serialTx (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          flush,
   input  logic                          baudTick,
   input  logic                          txStart,
   input  logic [lineFmtPkg::CHAR_W-1:0] txChar,
   input  lineFmtPkg::charLen_t          charLen,
   input  lineFmtPkg::parity_t           parity,
   input  lineFmtPkg::stopBits_t         stopBits,
   output logic                          txd,
   output logic                          txBusy
);

   import lineFmtPkg::*;

   typedef enum logic [2:0] {
      TX_IDLE,
      TX_ALIGN,
      TX_START,
      TX_DATA,
      TX_PARITY,
      TX_STOP
   } txState_t;

   txState_t          state;
   logic [CHAR_W-1:0] shiftReg;
   logic [3:0]        tickCnt;
   logic [2:0]        bitCnt;
   logic              parAcc;
   logic              stopLeft;
   // Format held for the whole frame
   charLen_t          fmtLen;
   parity_t           fmtPar;
   stopBits_t         fmtStop;

   ////////////////////
   // Transmit FSM
   ////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= TX_IDLE;
         txd      <= 1'b1;
         shiftReg <= '0;
         tickCnt  <= '0;
         bitCnt   <= '0;
         parAcc   <= 1'b0;
         stopLeft <= 1'b0;
         fmtLen   <= LEN8;
         fmtPar   <= PAR_NONE;
         fmtStop  <= STOP1;
      end
      else if (flush)
      begin
         state    <= TX_IDLE;
         txd      <= 1'b1;
         stopLeft <= 1'b0;
      end
      else
      begin
         case (state)
            TX_IDLE:
               if (txStart)
               begin
                  shiftReg <= txChar;
                  fmtLen   <= charLen;
                  fmtPar   <= parity;
                  fmtStop  <= stopBits;
                  state    <= TX_ALIGN;
               end
            // Frame edge lines up with the next tick
            TX_ALIGN:
               if (baudTick)
               begin
                  txd     <= 1'b0;
                  tickCnt <= 4'd15;
                  state   <= TX_START;
               end
            default:
               if (baudTick)
               begin
                  if (tickCnt != '0)
                     tickCnt <= tickCnt - 1'b1;
                  else
                  begin
                     tickCnt <= 4'd15;
                     case (state)
                        TX_START:
                        begin
                           txd      <= shiftReg[0];
                           parAcc   <= shiftReg[0];
                           shiftReg <= shiftReg >> 1;
                           bitCnt   <= '0;
                           state    <= TX_DATA;
                        end
                        TX_DATA:
                           if (bitCnt == ({1'b0, fmtLen} + 3'd4))
                           begin
                              stopLeft <= (fmtStop == STOP2);
                              if (fmtPar == PAR_NONE)
                              begin
                                 txd   <= 1'b1;
                                 state <= TX_STOP;
                              end
                              else
                              begin
                                 txd   <= parAcc ^ (fmtPar == PAR_ODD);
                                 state <= TX_PARITY;
                              end
                           end
                           else
                           begin
                              txd      <= shiftReg[0];
                              parAcc   <= parAcc ^ shiftReg[0];
                              shiftReg <= shiftReg >> 1;
                              bitCnt   <= bitCnt + 1'b1;
                           end
                        TX_PARITY:
                        begin
                           txd   <= 1'b1;
                           state <= TX_STOP;
                        end
                        // Second stop bit just repeats the high level
                        TX_STOP:
                           if (stopLeft)
                              stopLeft <= 1'b0;
                           else
                              state <= TX_IDLE;
                        default:
                           state <= TX_IDLE;
                     endcase
                  end
               end
         endcase
      end
   end

   assign txBusy = (state != TX_IDLE);

endmodule

//--- sim.f
+incdir+test
hdl/lineFmtPkg.sv
hdl/hostCmdPkg.sv
hdl/baudTickGen.sv
hdl/serialRx.sv
hdl/serialTx.sv
hdl/lineRegs.sv
hdl/serialLineTop.sv
test/serialLineTb.sv

//--- test/serialLineTbLib.svh
`ifndef SERIAL_LINE_TB_LIB_SVH
`define SERIAL_LINE_TB_LIB_SVH

////////////////////
// Random numbers
////////////////////

// LCG state, wraps at 32 bits
logic [31:0] lcgState = 32'd38708;

// Next pseudo-random byte from the middle bits
function automatic logic [7:0] lcgNext();
   lcgState = lcgState * 32'd1103515245 + 32'd12345;
   return lcgState[23:16];
endfunction

////////////////////
// Reference model
////////////////////

// Expected character and status for one frame
function automatic void refFrame(
   input  logic [CHAR_W-1:0] data,
   input  charLen_t          len,
   input  parity_t           par,
   input  logic              flipPar,
   input  logic              lowStop,
   output logic [CHAR_W-1:0] expData,
   output rxStat_t           expStat
);
   logic [CHAR_W-1:0] mask;
   // Keep only the low 5 to 8 bits
   mask           = 8'hFF >> (3 - int'(len));
   expData        = data & mask;
   // A flipped parity slot only matters when one is sent
   expStat.parErr = flipPar && (par != PAR_NONE);
   expStat.frmErr = lowStop;
   expStat.ovrErr = 1'b0;
endfunction

////////////////////
// Compare tasks
////////////////////

task automatic checkChar(input string name, input logic [CHAR_W-1:0] expV,
                         input logic [CHAR_W-1:0] actV);
   if (actV !== expV)
   begin
      dataErrs++;
      $display("FAIL %s: data expected %h actual %h", name, expV, actV);
   end
endtask

task automatic checkStat(input string name, input rxStat_t expV, input rxStat_t actV);
   if (actV !== expV)
   begin
      statErrs++;
      $display("FAIL %s: status expected %b actual %b", name, expV, actV);
   end
endtask

task automatic checkCount(input string name, input int expV, input int actV);
   if (actV != expV)
   begin
      countErrs++;
      $display("FAIL %s: count expected %0d actual %0d", name, expV, actV);
   end
endtask

////////////////////
// Bit-bang driver
////////////////////

// One bit time on the bit-bang line
task automatic holdBit(input logic level);
   bangLine = level;
   repeat (BIT_CLKS) @(posedge clk);
   #2;
endtask

// Start, data LSB first, optional parity, stop bits, then idle gap
task automatic bangFrame(
   input logic [CHAR_W-1:0] data,
   input charLen_t          len,
   input parity_t           par,
   input stopBits_t         stop,
   input logic              flipPar,
   input logic              lowStop
);
   int   nBits;
   logic parBit;
   nBits  = int'(len) + 5;
   parBit = 1'b0;
   holdBit(1'b0);
   for (int b = 0; b < nBits; b++)
   begin
      holdBit(data[b]);
      parBit = parBit ^ data[b];
   end
   if (par != PAR_NONE)
      holdBit(parBit ^ (par == PAR_ODD) ^ flipPar);
   // Bad stop is always the last one
   if (stop == STOP2)
      holdBit(1'b1);
   holdBit(!lowStop);
   holdBit(1'b1);
   holdBit(1'b1);
endtask

`endif

//--- test/serialLineTb.sv
`timescale 1ns/1ps

module serialLineTb;

   import lineFmtPkg::*;
   import hostCmdPkg::*;

   localparam int DIV_W     = 12;
   localparam int RXQ_DEPTH = 4;
   // Divisor 1 gives a tick every 2 clocks, 16 ticks a bit
   localparam int BIT_CLKS  = 32;
   localparam int NUM_LOOP  = 40;
   localparam int NUM_FRAMES = NUM_LOOP + 2 + 4 + (RXQ_DEPTH + 2) + 4;
   localparam int TIMEOUT_CYCLES = NUM_FRAMES * 12 * BIT_CLKS * 2 + 2000;

   // DUT ports
   logic              clk;
   logic              rst;
   logic              cfgWrite;
   cfgOp_t            cfgOp;
   logic [15:0]       cfgData;
   logic              rxCredit;
   logic              rxValid;
   logic [CHAR_W-1:0] rxData;
   rxStat_t           rxStat;
   logic              txValid;
   logic [CHAR_W-1:0] txData;
   logic              txCredit;
   logic              rxd;
   logic              txd;

   // Line source select and bit-bang level
   logic              useLoop;
   logic              bangLine;

   // Scoreboard and bookkeeping
   logic [CHAR_W-1:0] expChars [$];
   rxStat_t           expStats [$];
   string             testName;
   int                dataErrs;
   int                statErrs;
   int                countErrs;
   int                protoErrs;
   int                rxCreditsHeld;
   int                rxCount;
   int                txHeld;
   int                txReturned;
   int                rxBase;
   int                txBase;
   int                cycles;
   logic [CHAR_W-1:0] data;
   logic [CHAR_W-1:0] expD;
   rxStat_t           expS;
   charLen_t          len;
   parity_t           par;
   stopBits_t         stop;

   `include "serialLineTbLib.svh"

   serialLineTop #(
      .DIV_W     (DIV_W),
      .RXQ_DEPTH (RXQ_DEPTH)
   ) UUT (
      .clk      (clk),
      .rst      (rst),
      .cfgWrite (cfgWrite),
      .cfgOp    (cfgOp),
      .cfgData  (cfgData),
      .rxCredit (rxCredit),
      .rxValid  (rxValid),
      .rxData   (rxData),
      .rxStat   (rxStat),
      .txValid  (txValid),
      .txData   (txData),
      .txCredit (txCredit),
      .rxd      (rxd),
      .txd      (txd)
   );

   // Loopback or bit-bang source
   assign rxd = useLoop ? txd : bangLine;

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   ////////////////////
   // Host drive tasks
   ////////////////////

   // All of these start and end 2 ns after a rising edge
   task automatic setLine(input charLen_t l, input parity_t p, input stopBits_t s);
      cfgWrite = 1'b1;
      cfgOp    = OP_SET_LINE;
      cfgData  = 16'({s, p, l});
      @(posedge clk);
      #2;
      cfgWrite = 1'b0;
      cfgOp    = OP_NOP;
   endtask

   task automatic setDivisor(input int div);
      cfgWrite = 1'b1;
      cfgOp    = OP_SET_DIV;
      cfgData  = 16'(div);
      @(posedge clk);
      #2;
      cfgWrite = 1'b0;
      cfgOp    = OP_NOP;
   endtask

   task automatic flushLine();
      cfgWrite = 1'b1;
      cfgOp    = OP_FLUSH;
      @(posedge clk);
      #2;
      cfgWrite = 1'b0;
      cfgOp    = OP_NOP;
   endtask

   task automatic grantCredit();
      rxCredit = 1'b1;
      @(posedge clk);
      #2;
      rxCredit = 1'b0;
   endtask

   // Waits for a transmit credit before writing
   task automatic sendChar(input logic [CHAR_W-1:0] d);
      while (txHeld == 0)
      begin
         @(posedge clk);
         #2;
      end
      txValid = 1'b1;
      txData  = d;
      txHeld--;
      @(posedge clk);
      #2;
      txValid = 1'b0;
   endtask

   task automatic expectFrame(input logic [CHAR_W-1:0] d, input charLen_t l, input parity_t p,
                              input logic flipPar, input logic lowStop, input logic ovr);
      refFrame(d, l, p, flipPar, lowStop, expD, expS);
      expS.ovrErr = ovr;
      expChars.push_back(expD);
      expStats.push_back(expS);
   endtask

   task automatic waitDrained();
      while (expChars.size() != 0)
      begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic idleBits(input int n);
      repeat (n * BIT_CLKS) @(posedge clk);
      #2;
   endtask

   ////////////////////
   // Scoreboard
   ////////////////////

   // Sampled at the edge, inputs move 2 ns later
   always @(posedge clk)
   begin
      if (!rst)
      begin
         if (rxValid)
         begin
            rxCount++;
            if (rxCreditsHeld == 0)
            begin
               protoErrs++;
               $display("rxValid asserted with no receive credit held in %s", testName);
            end
            if (expChars.size() == 0)
            begin
               protoErrs++;
               $display("Unexpected character %h delivered in %s", rxData, testName);
            end
            else
            begin
               checkChar(testName, expChars.pop_front(), rxData);
               checkStat(testName, expStats.pop_front(), rxStat);
            end
         end
         rxCreditsHeld = rxCreditsHeld + int'(rxCredit) - int'(rxValid);
         if (txCredit)
         begin
            txReturned++;
            txHeld++;
         end
      end
   end

   // Hang guard
   initial
   begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles with %0d characters outstanding",
               cycles, expChars.size());
      $display("Regression failed");
      $finish;
   end

   ////////////////////
   // Test sequence
   ////////////////////

   initial
   begin
      rst           = 1'b1;
      cfgWrite      = 1'b0;
      cfgOp         = OP_NOP;
      cfgData       = '0;
      rxCredit      = 1'b0;
      txValid       = 1'b0;
      txData        = '0;
      useLoop       = 1'b0;
      bangLine      = 1'b1;
      testName      = "reset";
      dataErrs      = 0;
      statErrs      = 0;
      countErrs     = 0;
      protoErrs     = 0;
      rxCreditsHeld = 0;
      rxCount       = 0;
      txHeld        = 1;
      txReturned    = 0;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      setDivisor(1);
      idleBits(1);

      // Loopback over every length and parity, stop bits alternating per dozen
      testName = "loopback";
      useLoop  = 1'b1;
      txBase   = txReturned;
      for (int i = 0; i < NUM_LOOP; i++)
      begin
         len  = charLen_t'(i % 4);
         par  = parity_t'((i / 4) % 3);
         stop = stopBits_t'((i / 12) % 2);
         data = lcgNext();
         setLine(len, par, stop);
         expectFrame(data, len, par, 1'b0, 1'b0, 1'b0);
         grantCredit();
         sendChar(data);
         waitDrained();
      end
      checkCount(testName, NUM_LOOP, txReturned - txBase);

      // Flipped parity slot, even then odd
      testName = "parity";
      useLoop  = 1'b0;
      for (int p = 1; p < 3; p++)
      begin
         data = lcgNext();
         setLine(LEN7, parity_t'(p), STOP1);
         expectFrame(data, LEN7, parity_t'(p), 1'b1, 1'b0, 1'b0);
         grantCredit();
         bangFrame(data, LEN7, parity_t'(p), STOP1, 1'b1, 1'b0);
         waitDrained();
      end

      // Low last stop bit with one and two stop bits
      testName = "framing";
      for (int s = 0; s < 2; s++)
      begin
         data = lcgNext();
         setLine(LEN8, PAR_EVEN, stopBits_t'(s));
         expectFrame(data, LEN8, PAR_EVEN, 1'b0, 1'b1, 1'b0);
         grantCredit();
         bangFrame(data, LEN8, PAR_EVEN, stopBits_t'(s), 1'b0, 1'b1);
         waitDrained();
      end

      // Quarter-bit start glitch, the next real frame must be the first delivered
      testName = "glitch";
      setLine(LEN8, PAR_NONE, STOP1);
      grantCredit();
      bangLine = 1'b0;
      repeat (BIT_CLKS / 4) @(posedge clk);
      #2;
      bangLine = 1'b1;
      idleBits(3);
      data = lcgNext();
      expectFrame(data, LEN8, PAR_NONE, 1'b0, 1'b0, 1'b0);
      bangFrame(data, LEN8, PAR_NONE, STOP1, 1'b0, 1'b0);
      waitDrained();

      // Queue overrun with credits held back
      testName = "overrun";
      rxBase   = rxCount;
      for (int k = 0; k < RXQ_DEPTH + 2; k++)
      begin
         data = lcgNext();
         if (k < RXQ_DEPTH)
            expectFrame(data, LEN8, PAR_NONE, 1'b0, 1'b0, k == RXQ_DEPTH - 1);
         bangFrame(data, LEN8, PAR_NONE, STOP1, 1'b0, 1'b0);
      end
      checkCount(testName, 0, rxCount - rxBase);
      for (int k = 0; k < RXQ_DEPTH + 2; k++)
         grantCredit();
      waitDrained();
      idleBits(2);
      checkCount(testName, RXQ_DEPTH, rxCount - rxBase);

      // Two spare credits left, the third frame stays queued
      testName = "flush";
      for (int k = 0; k < 3; k++)
      begin
         data = lcgNext();
         if (k < 2)
            expectFrame(data, LEN8, PAR_NONE, 1'b0, 1'b0, 1'b0);
         bangFrame(data, LEN8, PAR_NONE, STOP1, 1'b0, 1'b0);
      end
      waitDrained();
      // Char in the holding register dies with the flush
      sendChar(lcgNext());
      flushLine();
      txHeld = 1;
      rxBase = rxCount;
      txBase = txReturned;
      grantCredit();
      idleBits(4);
      checkCount(testName, 0, rxCount - rxBase);
      useLoop = 1'b1;
      data    = lcgNext();
      expectFrame(data, LEN8, PAR_NONE, 1'b0, 1'b0, 1'b0);
      sendChar(data);
      waitDrained();
      checkCount(testName, 1, txReturned - txBase);
      checkCount(testName, 1, txHeld);

      $display("Error counts: data %0d status %0d count %0d protocol %0d",
               dataErrs, statErrs, countErrs, protoErrs);
      if (dataErrs + statErrs + countErrs + protoErrs == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule
